// File: ex_stage_pkg.sv
`default_nettype none

package ex_stage_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data word and register address
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Shift amount taken from the low bits of operand B
  localparam int SHAMT_W    = $clog2(XLEN);

  // One restoring step per quotient bit
  localparam int DIV_STEPS  = XLEN;
  localparam int DIV_CNT_W  = $clog2(DIV_STEPS);

  ////////////////////////////////////////////////////////////
  // Operators
  ////////////////////////////////////////////////////////////

  // ALU codes, the upper six are compare-only
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_BEQ  = 4'hA,
    ALU_BNE  = 4'hB,
    ALU_BLT  = 4'hC,
    ALU_BGE  = 4'hD,
    ALU_BLTU = 4'hE,
    ALU_BGEU = 4'hF
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL_MUL    = 2'h0,
    MUL_MULH   = 2'h1,
    MUL_MULHSU = 2'h2,
    MUL_MULHU  = 2'h3
  } mul_op_e;

  typedef enum logic [1:0] {
    DIV_DIV  = 2'h0,
    DIV_DIVU = 2'h1,
    DIV_REM  = 2'h2,
    DIV_REMU = 2'h3
  } div_op_e;

endpackage

`default_nettype wire

// File: ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_stage_pkg::alu_op_e         operator_i,
  input  logic [ex_stage_pkg::XLEN-1:0] operand_a_i,
  input  logic [ex_stage_pkg::XLEN-1:0] operand_b_i,
  output logic [ex_stage_pkg::XLEN-1:0] result_o,
  output logic                          cmp_result_o
);
  import ex_stage_pkg::*;

  logic               is_sub;
  logic [XLEN-1:0]    adder_b;
  logic [XLEN:0]      adder_sum;
  logic               is_equal;
  logic               lt_signed;
  logic               lt_unsigned;
  logic               shift_left;
  logic               shift_arith;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    shift_in;
  logic [XLEN:0]      shift_ext;
  logic [XLEN:0]      shift_raw;
  logic [XLEN-1:0]    shift_out;

  ////////////////////////////////////////////////////////////
  // Adder, shared by add, subtract and all compares
  ////////////////////////////////////////////////////////////

  // Everything except ADD subtracts
  assign is_sub    = (operator_i != ALU_ADD);
  assign adder_b   = is_sub ? ~operand_b_i : operand_b_i;
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + {{XLEN{1'b0}}, is_sub};

  assign is_equal    = (adder_sum[XLEN-1:0] == '0);
  // No carry out of a - b means a < b unsigned
  assign lt_unsigned = ~adder_sum[XLEN];
  // Differing signs decide directly, else the difference sign
  assign lt_signed   = (operand_a_i[XLEN-1] != operand_b_i[XLEN-1]) ? operand_a_i[XLEN-1]
                                                                   : adder_sum[XLEN-1];

  ////////////////////////////////////////////////////////////
  // Shifter, right only, left by bit reversal
  ////////////////////////////////////////////////////////////

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);
  assign shamt       = operand_b_i[SHAMT_W-1:0];

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      shift_in[i] = shift_left ? operand_a_i[XLEN-1-i] : operand_a_i[i];
    end
    // Extra top bit carries the sign for SRA
    shift_ext = {shift_arith & operand_a_i[XLEN-1], shift_in};
    shift_raw = $signed(shift_ext) >>> shamt;
    for (int i = 0; i < XLEN; i++) begin
      shift_out[i] = shift_left ? shift_raw[XLEN-1-i] : shift_raw[i];
    end
  end

  // Result mux
  always_comb begin
    case (operator_i)
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL,
      ALU_SRL,
      ALU_SRA:  result_o = shift_out;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      default:  result_o = adder_sum[XLEN-1:0];
    endcase
  end

  // Branch compare
  always_comb begin
    case (operator_i)
      ALU_BEQ:  cmp_result_o = is_equal;
      ALU_BNE:  cmp_result_o = ~is_equal;
      ALU_BLT:  cmp_result_o = lt_signed;
      ALU_BGE:  cmp_result_o = ~lt_signed;
      ALU_BLTU: cmp_result_o = lt_unsigned;
      ALU_BGEU: cmp_result_o = ~lt_unsigned;
      default:  cmp_result_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: ex_mult.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mult (
  input  logic                          clk,
  input  logic                          rst_n,
  input  ex_stage_pkg::mul_op_e         operator_i,
  input  logic [ex_stage_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_stage_pkg::XLEN-1:0] op_b_i,
  input  logic                          valid_i,
  input  logic                          ready_i,
  output logic                          ready_o,
  output logic                          valid_o,
  output logic [ex_stage_pkg::XLEN-1:0] result_o
);
  import ex_stage_pkg::*;

  logic                     a_signed;
  logic                     b_signed;
  logic signed [XLEN:0]     a_ext;
  logic signed [XLEN:0]     b_ext;
  logic signed [2*XLEN+1:0] product_q;
  logic                     sel_high_q;
  logic                     busy_q;
  logic                     start;

  // Sign handling per operator
  assign a_signed = (operator_i == MUL_MULH) || (operator_i == MUL_MULHSU);
  assign b_signed = (operator_i == MUL_MULH);
  assign a_ext    = {a_signed & op_a_i[XLEN-1], op_a_i};
  assign b_ext    = {b_signed & op_b_i[XLEN-1], op_b_i};

  // First cycle of a new multiply
  assign start = valid_i && !busy_q;

  // Busy while a product waits for write-back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (!valid_i) begin
      // Killed or halted, drop the product
      busy_q <= 1'b0;
    end else if (!busy_q) begin
      busy_q <= 1'b1;
    end else if (ready_i) begin
      busy_q <= 1'b0;
    end
  end

  // Product and word select
  always_ff @(posedge clk) begin
    if (start) begin
      product_q  <= a_ext * b_ext;
      sel_high_q <= (operator_i != MUL_MUL);
    end
  end

  assign result_o = sel_high_q ? product_q[2*XLEN-1:XLEN] : product_q[XLEN-1:0];
  assign valid_o  = busy_q;
  // Stall decode until the product has left
  assign ready_o  = (!busy_q && !valid_i) || (busy_q && ready_i);

endmodule

`default_nettype wire

// File: ex_div.sv
`timescale 1ns/1ps
`default_nettype none

module ex_div (
  input  logic                          clk,
  input  logic                          rst_n,
  input  ex_stage_pkg::div_op_e         operator_i,
  input  logic [ex_stage_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_stage_pkg::XLEN-1:0] op_b_i,
  input  logic                          valid_i,
  input  logic                          ready_i,
  output logic                          ready_o,
  output logic                          valid_o,
  output logic [ex_stage_pkg::XLEN-1:0] result_o
);
  import ex_stage_pkg::*;

  logic                 is_signed;
  logic                 a_neg;
  logic                 b_neg;
  logic [XLEN-1:0]      a_mag;
  logic [XLEN-1:0]      b_mag;
  logic                 load;
  logic                 busy_q;
  logic                 done_q;
  logic [DIV_CNT_W-1:0] cnt_q;
  logic [XLEN-1:0]      rem_q;
  logic [XLEN-1:0]      quo_q;
  logic [XLEN-1:0]      divisor_q;
  logic                 quo_neg_q;
  logic                 rem_neg_q;
  logic                 is_rem_q;
  logic [XLEN:0]        rem_shift;
  logic [XLEN:0]        rem_diff;

  ////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////

  assign is_signed = (operator_i == DIV_DIV) || (operator_i == DIV_REM);
  assign a_neg     = is_signed && op_a_i[XLEN-1];
  assign b_neg     = is_signed && op_b_i[XLEN-1];
  // Most negative value keeps its bits as magnitude 2^(XLEN-1)
  assign a_mag     = a_neg ? -op_a_i : op_a_i;
  assign b_mag     = b_neg ? -op_b_i : op_b_i;

  assign load = valid_i && !busy_q && !done_q;

  // Control, one load cycle then DIV_STEPS steps
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (!valid_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (load) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == DIV_CNT_W'(DIV_STEPS - 1)) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end else if (ready_i) begin
      done_q <= 1'b0;
    end
  end

  // Restoring step, shift in next dividend bit and try subtract
  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor_q};

  // Datapath
  always_ff @(posedge clk) begin
    if (load) begin
      rem_q     <= '0;
      quo_q     <= a_mag;
      divisor_q <= b_mag;
      // Zero divisor keeps the all-ones quotient unsigned
      quo_neg_q <= (a_neg ^ b_neg) && (op_b_i != '0);
      rem_neg_q <= a_neg;
      is_rem_q  <= (operator_i == DIV_REM) || (operator_i == DIV_REMU);
    end else if (busy_q) begin
      if (!rem_diff[XLEN]) begin
        rem_q <= rem_diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= rem_shift[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  // Sign fix and select
  assign result_o = is_rem_q ? (rem_neg_q ? -rem_q : rem_q)
                             : (quo_neg_q ? -quo_q : quo_q);
  assign valid_o  = done_q;
  assign ready_o  = (!busy_q && !done_q && !valid_i) || (done_q && ready_i);

endmodule

`default_nettype wire

// File: ex_wb_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_wb_reg (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                ex_valid_i,
  input  logic                                wb_ready_i,
  input  logic                                mul_en_i,
  input  logic                                div_en_i,
  input  logic [ex_stage_pkg::XLEN-1:0]       alu_result_i,
  input  logic [ex_stage_pkg::XLEN-1:0]       mul_result_i,
  input  logic [ex_stage_pkg::XLEN-1:0]       div_result_i,
  input  logic                                rf_we_i,
  input  logic [ex_stage_pkg::REG_ADDR_W-1:0] rf_waddr_i,
  input  logic [ex_stage_pkg::XLEN-1:0]       pc_i,
  input  logic                                branch_taken_i,
  output logic                                wb_valid_o,
  output logic                                wb_rf_we_o,
  output logic                                wb_branch_taken_o,
  output logic [ex_stage_pkg::REG_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [ex_stage_pkg::XLEN-1:0]       wb_rf_wdata_o,
  output logic [ex_stage_pkg::XLEN-1:0]       wb_pc_o
);
  import ex_stage_pkg::*;

  logic [XLEN-1:0] wdata_sel;
  logic            load;

  // Result select, ALU by default
  always_comb begin
    if (mul_en_i) begin
      wdata_sel = mul_result_i;
    end else if (div_en_i) begin
      wdata_sel = div_result_i;
    end else begin
      wdata_sel = alu_result_i;
    end
  end

  assign load = ex_valid_i && wb_ready_i;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o        <= 1'b0;
      wb_rf_we_o        <= 1'b0;
      wb_branch_taken_o <= 1'b0;
    end else if (load) begin
      wb_valid_o        <= 1'b1;
      wb_rf_we_o        <= rf_we_i;
      wb_branch_taken_o <= branch_taken_i;
    end else if (wb_ready_i) begin
      // Nothing to pass on, so send a bubble
      wb_valid_o <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (load) begin
      wb_pc_o <= pc_i;
      // Write data only moves for register writes
      if (rf_we_i) begin
        wb_rf_waddr_o <= rf_waddr_i;
        wb_rf_wdata_o <= wdata_sel;
      end
    end
  end

endmodule

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                                clk,
  input  logic                                rst_n,
  // Decode side
  input  logic                                instr_valid_i,
  input  logic                                alu_en_i,
  input  logic                                mul_en_i,
  input  logic                                div_en_i,
  input  logic                                branch_en_i,
  input  ex_stage_pkg::alu_op_e               alu_operator_i,
  input  ex_stage_pkg::mul_op_e               mul_operator_i,
  input  ex_stage_pkg::div_op_e               div_operator_i,
  input  logic [ex_stage_pkg::XLEN-1:0]       operand_a_i,
  input  logic [ex_stage_pkg::XLEN-1:0]       operand_b_i,
  input  logic [ex_stage_pkg::XLEN-1:0]       operand_c_i,
  input  logic                                rf_we_i,
  input  logic [ex_stage_pkg::REG_ADDR_W-1:0] rf_waddr_i,
  input  logic [ex_stage_pkg::XLEN-1:0]       pc_i,
  output logic                                ex_ready_o,
  // Controller
  input  logic                                kill_ex_i,
  input  logic                                halt_ex_i,
  // Branch to fetch
  output logic                                branch_decision_o,
  output logic [ex_stage_pkg::XLEN-1:0]       branch_target_o,
  // Write-back side
  output logic                                wb_valid_o,
  output logic                                wb_rf_we_o,
  output logic [ex_stage_pkg::REG_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [ex_stage_pkg::XLEN-1:0]       wb_rf_wdata_o,
  output logic [ex_stage_pkg::XLEN-1:0]       wb_pc_o,
  output logic                                wb_branch_taken_o,
  input  logic                                wb_ready_i
);
  import ex_stage_pkg::*;

  logic            instr_valid;
  logic            alu_ready;
  logic            mul_valid_in;
  logic            mul_valid;
  logic            mul_ready;
  logic            div_valid_in;
  logic            div_valid;
  logic            div_ready;
  logic            ex_valid;
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic [XLEN-1:0] mul_result;
  logic [XLEN-1:0] div_result;

  // Kill and halt mask the instruction
  assign instr_valid  = instr_valid_i && !kill_ex_i && !halt_ex_i;
  assign mul_valid_in = mul_en_i && instr_valid;
  assign div_valid_in = div_en_i && instr_valid;

  // Single-cycle ALU
  assign alu_ready = wb_ready_i;

  // Enabled unit has a result, the ALU always does
  assign ex_valid = (alu_en_i ||
                     (mul_en_i && mul_valid) ||
                     (div_en_i && div_valid)) && instr_valid;

  // Kill frees the stage at once
  assign ex_ready_o = kill_ex_i || (alu_ready && mul_ready && div_ready && !halt_ex_i);

  // Branch outputs in the same cycle
  assign branch_decision_o = alu_cmp_result && branch_en_i && instr_valid;
  assign branch_target_o   = operand_c_i;

  ////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (mul_operator_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .valid_i    (mul_valid_in),
    .ready_i    (wb_ready_i),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid),
    .result_o   (mul_result)
  );

  ex_div u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (div_operator_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .valid_i    (div_valid_in),
    .ready_i    (wb_ready_i),
    .ready_o    (div_ready),
    .valid_o    (div_valid),
    .result_o   (div_result)
  );

  // EX/WB register
  ex_wb_reg u_ex_wb (
    .clk               (clk),
    .rst_n             (rst_n),
    .ex_valid_i        (ex_valid),
    .wb_ready_i        (wb_ready_i),
    .mul_en_i          (mul_en_i),
    .div_en_i          (div_en_i),
    .alu_result_i      (alu_result),
    .mul_result_i      (mul_result),
    .div_result_i      (div_result),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .pc_i              (pc_i),
    .branch_taken_i    (branch_decision_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_branch_taken_o (wb_branch_taken_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_pc_o           (wb_pc_o)
  );

endmodule

`default_nettype wire

// File: tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
  import ex_stage_pkg::*;

  localparam int NT         = 30;
  localparam int MAX_CYCLES = NT * 60 + 100;
  localparam int U_ALU      = 0;
  localparam int U_MUL      = 1;
  localparam int U_DIV      = 2;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid_i;
  logic                  alu_en_i;
  logic                  mul_en_i;
  logic                  div_en_i;
  logic                  branch_en_i;
  alu_op_e               alu_operator_i;
  mul_op_e               mul_operator_i;
  div_op_e               div_operator_i;
  logic [XLEN-1:0]       operand_a_i;
  logic [XLEN-1:0]       operand_b_i;
  logic [XLEN-1:0]       operand_c_i;
  logic                  rf_we_i;
  logic [REG_ADDR_W-1:0] rf_waddr_i;
  logic [XLEN-1:0]       pc_i;
  logic                  ex_ready_o;
  logic                  kill_ex_i;
  logic                  halt_ex_i;
  logic                  branch_decision_o;
  logic [XLEN-1:0]       branch_target_o;
  logic                  wb_valid_o;
  logic                  wb_rf_we_o;
  logic [REG_ADDR_W-1:0] wb_rf_waddr_o;
  logic [XLEN-1:0]       wb_rf_wdata_o;
  logic [XLEN-1:0]       wb_pc_o;
  logic                  wb_branch_taken_o;
  logic                  wb_ready_i;

  // Test table with one extra slot for the reset test
  string           t_name [NT+1];
  int              t_unit [NT];
  logic [3:0]      t_op [NT];
  bit              t_br [NT];
  logic [XLEN-1:0] t_a [NT];
  logic [XLEN-1:0] t_b [NT];
  logic [XLEN-1:0] t_c [NT];
  bit              t_kill [NT];
  logic [XLEN-1:0] t_exp [NT];
  bit              t_taken [NT];
  bit              test_bad [NT+1];
  int              n_tests;
  int              errors;
  int              cycles = 0;
  // Accepted entries still owed a write-back beat in age order
  int              pending [$];

  ex_stage dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_valid_i     (instr_valid_i),
    .alu_en_i          (alu_en_i),
    .mul_en_i          (mul_en_i),
    .div_en_i          (div_en_i),
    .branch_en_i       (branch_en_i),
    .alu_operator_i    (alu_operator_i),
    .mul_operator_i    (mul_operator_i),
    .div_operator_i    (div_operator_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .operand_c_i       (operand_c_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .pc_i              (pc_i),
    .ex_ready_o        (ex_ready_o),
    .kill_ex_i         (kill_ex_i),
    .halt_ex_i         (halt_ex_i),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_pc_o           (wb_pc_o),
    .wb_branch_taken_o (wb_branch_taken_o),
    .wb_ready_i        (wb_ready_i)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  // Write-back back-pressure with ready about 70 percent of cycles
  always @(posedge clk) begin
    #2;
    wb_ready_i = (($urandom % 100) < 70);
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the stage stopped making progress", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [REG_ADDR_W-1:0] dest_addr(input int i);
    return REG_ADDR_W'(i % 31 + 1);
  endfunction

  function automatic logic [XLEN-1:0] instr_pc(input int i);
    return 32'h0000_1000 + XLEN'(4 * i);
  endfunction

  ////////////////////////////////////////////////////////////
  // Table entry helpers
  ////////////////////////////////////////////////////////////

  task automatic add_test(input string name, input int unit, input logic [3:0] op,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                          input bit kill, input logic [XLEN-1:0] exp);
    t_name[n_tests]  = name;
    t_unit[n_tests]  = unit;
    t_op[n_tests]    = op;
    t_br[n_tests]    = 1'b0;
    t_a[n_tests]     = a;
    t_b[n_tests]     = b;
    t_c[n_tests]     = '0;
    t_kill[n_tests]  = kill;
    t_exp[n_tests]   = exp;
    t_taken[n_tests] = 1'b0;
    n_tests++;
  endtask

  // Branches write no register, only the decision is checked
  task automatic add_branch(input string name, input logic [3:0] op,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                            input logic [XLEN-1:0] c, input bit taken);
    add_test(name, U_ALU, op, a, b, 1'b0, '0);
    t_br[n_tests-1]    = 1'b1;
    t_c[n_tests-1]     = c;
    t_taken[n_tests-1] = taken;
  endtask

  task automatic build_table();
    // ALU
    add_test("add_ovf",        U_ALU, ALU_ADD,  32'h7fffffff, 32'h00000001, 0, 32'h80000000);
    add_test("sub_neg",        U_ALU, ALU_SUB,  32'h00000005, 32'h00000007, 0, 32'hfffffffe);
    add_test("and_mask",       U_ALU, ALU_AND,  32'hf0f01234, 32'h0ff0ffff, 0, 32'h00f01234);
    add_test("or_bits",        U_ALU, ALU_OR,   32'hf0000001, 32'h00001000, 0, 32'hf0001001);
    add_test("xor_half",       U_ALU, ALU_XOR,  32'haaaa5555, 32'hffff0000, 0, 32'h55555555);
    // Shift amount is the low 5 bits of B
    add_test("sll_shamt",      U_ALU, ALU_SLL,  32'h00000013, 32'h00000024, 0, 32'h00000130);
    add_test("srl_logic",      U_ALU, ALU_SRL,  32'h80000010, 32'h00000004, 0, 32'h08000001);
    add_test("sra_arith",      U_ALU, ALU_SRA,  32'h80000010, 32'h00000004, 0, 32'hf8000001);
    add_test("slt_signed",     U_ALU, ALU_SLT,  32'hfffffffe, 32'h00000001, 0, 32'h00000001);
    add_test("sltu_unsigned",  U_ALU, ALU_SLTU, 32'hfffffffe, 32'h00000001, 0, 32'h00000000);
    // Branch compares
    add_branch("beq_taken",      ALU_BEQ,  32'h00001234, 32'h00001234, 32'h00000400, 1);
    add_branch("bne_not_taken",  ALU_BNE,  32'h00001234, 32'h00001234, 32'h00000410, 0);
    add_branch("blt_taken",      ALU_BLT,  32'h80000000, 32'h00000000, 32'h00000420, 1);
    add_branch("bge_taken",      ALU_BGE,  32'h00000005, 32'hffffffff, 32'h00000430, 1);
    add_branch("bltu_taken",     ALU_BLTU, 32'h00000005, 32'hffffffff, 32'h00000440, 1);
    add_branch("bgeu_not_taken", ALU_BGEU, 32'h00000005, 32'hffffffff, 32'h00000450, 0);
    // Multiplier gives the low word for MUL and the high word otherwise
    add_test("mul_low",        U_MUL, MUL_MUL,    32'hffffffff, 32'h00000007, 0, 32'hfffffff9);
    add_test("mulh_minmin",    U_MUL, MUL_MULH,   32'h80000000, 32'h80000000, 0, 32'h40000000);
    add_test("mulhsu_mixed",   U_MUL, MUL_MULHSU, 32'hffffffff, 32'hffffffff, 0, 32'hffffffff);
    add_test("mulhu_max",      U_MUL, MUL_MULHU,  32'hffffffff, 32'hffffffff, 0, 32'hfffffffe);
    // Divider where -100 / 7 truncates toward zero
    add_test("div_neg",        U_DIV, DIV_DIV,  32'hffffff9c, 32'h00000007, 0, 32'hfffffff2);
    add_test("rem_neg",        U_DIV, DIV_REM,  32'hffffff9c, 32'h00000007, 0, 32'hfffffffe);
    add_test("divu_by_zero",   U_DIV, DIV_DIVU, 32'h00000064, 32'h00000000, 0, 32'hffffffff);
    add_test("remu_by_zero",   U_DIV, DIV_REMU, 32'h00000064, 32'h00000000, 0, 32'h00000064);
    add_test("rem_by_zero",    U_DIV, DIV_REM,  32'hfffffffb, 32'h00000000, 0, 32'hfffffffb);
    add_test("div_overflow",   U_DIV, DIV_DIV,  32'h80000000, 32'hffffffff, 0, 32'h80000000);
    add_test("rem_overflow",   U_DIV, DIV_REM,  32'h80000000, 32'hffffffff, 0, 32'h00000000);
    // Divide killed in flight and a clean divide with other operands behind it
    add_test("div_killed",     U_DIV, DIV_DIVU, 32'h000003e8, 32'h00000003, 1, 32'h00000000);
    add_test("divu_after_kill", U_DIV, DIV_DIVU, 32'h000003e8, 32'h00000007, 0, 32'h0000008e);
    add_test("add_final",      U_ALU, ALU_ADD,  32'h12345678, 32'h11111111, 0, 32'h23456789);
    t_name[NT] = "reset";
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input int idx, input string what,
                          input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    if (exp !== act) begin
      $display("Fail %s.%s expected %h actual %h", t_name[idx], what, exp, act);
      test_bad[idx] = 1'b1;
      errors++;
    end
  endtask

  // One write-back beat against its table entry
  task automatic check_beat(input int i);
    check_eq(i, "pc", instr_pc(i), wb_pc_o);
    check_eq(i, "taken", XLEN'(t_br[i] && t_taken[i]), XLEN'(wb_branch_taken_o));
    check_eq(i, "we", XLEN'(!t_br[i]), XLEN'(wb_rf_we_o));
    if (!t_br[i]) begin
      check_eq(i, "waddr", XLEN'(dest_addr(i)), XLEN'(wb_rf_waddr_o));
      check_eq(i, "wdata", t_exp[i], wb_rf_wdata_o);
    end
    $display("Test %-16s %s", t_name[i], test_bad[i] ? "FAILED" : "ok");
  endtask

  // Idle stage right after reset
  task automatic check_reset();
    repeat (4) begin
      @(negedge clk);
      check_eq(NT, "wb_valid", '0, XLEN'(wb_valid_o));
      check_eq(NT, "wb_rf_we", '0, XLEN'(wb_rf_we_o));
      check_eq(NT, "ex_ready", XLEN'(wb_ready_i), XLEN'(ex_ready_o));
    end
    $display("Test %-16s %s", t_name[NT], test_bad[NT] ? "FAILED" : "ok");
    @(posedge clk);
    #2;
  endtask

  // Present one entry and hold it until the stage takes it
  task automatic issue(input int i);
    int waited;
    bit accepted;
    waited         = 0;
    accepted       = 1'b0;
    alu_en_i       = (t_unit[i] == U_ALU);
    mul_en_i       = (t_unit[i] == U_MUL);
    div_en_i       = (t_unit[i] == U_DIV);
    branch_en_i    = t_br[i];
    alu_operator_i = alu_op_e'(t_op[i]);
    mul_operator_i = mul_op_e'(t_op[i][1:0]);
    div_operator_i = div_op_e'(t_op[i][1:0]);
    operand_a_i    = t_a[i];
    operand_b_i    = t_b[i];
    operand_c_i    = t_c[i];
    rf_we_i        = !t_br[i];
    rf_waddr_i     = dest_addr(i);
    pc_i           = instr_pc(i);
    instr_valid_i  = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      // Branch outputs while the instruction sits in EX
      if (t_br[i] && waited == 0) begin
        check_eq(i, "decision", XLEN'(t_taken[i]), XLEN'(branch_decision_o));
        check_eq(i, "target", t_c[i], branch_target_o);
      end
      accepted = ex_ready_o;
      @(posedge clk);
      #2;
      waited++;
      // Kill the divide a few cycles into its run
      if (!accepted && t_kill[i] && waited == 3) begin
        kill_ex_i = 1'b1;
      end
    end
    instr_valid_i = 1'b0;
    kill_ex_i     = 1'b0;
    if (t_kill[i]) begin
      $display("Test %-16s killed in flight, no write-back", t_name[i]);
    end else begin
      pending.push_back(i);
    end
  endtask

  // Write-back monitor counts a beat when valid meets ready
  always @(negedge clk) begin
    int idx;
    if (rst_n && wb_valid_o && wb_ready_i) begin
      if (pending.size() == 0) begin
        $display("Write-back beat with pc %h arrived with no instruction owed", wb_pc_o);
        errors++;
      end else begin
        idx = pending.pop_front();
        check_beat(idx);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int pass_cnt;
    int fail_cnt;
    void'($urandom(49));
    clk            = 1'b0;
    rst_n          = 1'b0;
    instr_valid_i  = 1'b0;
    alu_en_i       = 1'b0;
    mul_en_i       = 1'b0;
    div_en_i       = 1'b0;
    branch_en_i    = 1'b0;
    alu_operator_i = ALU_ADD;
    mul_operator_i = MUL_MUL;
    div_operator_i = DIV_DIV;
    operand_a_i    = '0;
    operand_b_i    = '0;
    operand_c_i    = '0;
    rf_we_i        = 1'b0;
    rf_waddr_i     = '0;
    pc_i           = '0;
    kill_ex_i      = 1'b0;
    halt_ex_i      = 1'b0;
    wb_ready_i     = 1'b0;
    n_tests        = 0;
    errors         = 0;
    build_table();
    if (n_tests != NT) begin
      $display("Test table holds %0d entries instead of %0d", n_tests, NT);
      errors++;
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_reset();
    for (int i = 0; i < NT; i++) begin
      issue(i);
    end
    // Drain the pipeline, then leave room for a stray beat
    while (pending.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);
    pass_cnt = 0;
    fail_cnt = 0;
    for (int i = 0; i <= NT; i++) begin
      if (test_bad[i]) begin
        fail_cnt++;
      end else begin
        pass_cnt++;
      end
    end
    $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ex_stage.f
ex_stage_pkg.sv
ex_alu.sv
ex_mult.sv
ex_div.sv
ex_wb_reg.sv
ex_stage.sv
tb_ex_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the pass line
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_ex_stage -f ex_stage.f -o vsim \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/vsim > sim.log 2>&1 ; cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1
